//--- source/soc_bus_defs.svh
`ifndef SOC_BUS_DEFS_SVH
`define SOC_BUS_DEFS_SVH

// ========================================
// Bus widths

`define SB_DATA_W 32

// ========================================
// Region decode on address bits 31..28

`define SB_REGION_HI 31
`define SB_REGION_LO 28
`define SB_REGION_RAM 4'h1
`define SB_REGION_BRIDGE 4'h5

// Far slot decode behind the bridge
`define SB_FAR_HI 27
`define SB_FAR_LO 24
`define SB_FAR_LED 4'h0
`define SB_FAR_TIMER 4'h5

// On-chip RAM geometry
`define SB_RAM_WORDS 512
`define SB_RAM_AW 9

`define SB_LED_W 10

// Fault source codes
`define SB_SRC_INSTR 2'd1
`define SB_SRC_DATA 2'd2

`endif

//--- source/soc_bus_pkg.sv
`include "soc_bus_defs.svh"

package soc_bus_pkg;

	// ========================================
	// Bus transfer types

	// Requesting port as reported in a fault
	typedef logic [1:0] src_t;

	// Request from the arbiter, rw high means write
	typedef struct packed {
		logic rw;
		logic [`SB_DATA_W-1:0] address;
		logic [`SB_DATA_W-1:0] wdata;
	} bus_req_t;

	// Slave answer, ready is a single-cycle pulse
	typedef struct packed {
		logic ready;
		logic [`SB_DATA_W-1:0] rdata;
	} bus_rsp_t;

	// ========================================
	// Fault report

	// Access to an unmapped region
	typedef struct packed {
		logic valid;
		logic [`SB_DATA_W-1:0] address;
		src_t src;
	} bus_fault_t;

endpackage

//--- source/bus_arbiter.sv
`timescale 1ns/1ps

`include "soc_bus_defs.svh"

module bus_arbiter import soc_bus_pkg::*; (
	input i_clock,
	input i_rst,

	// Port A, instruction fetch
	input i_pa_request,
	input [`SB_DATA_W-1:0] i_pa_address,
	output logic o_pa_ready,
	output logic [`SB_DATA_W-1:0] o_pa_rdata,

	// Port B, data access
	input i_pb_request,
	input i_pb_rw,
	input [`SB_DATA_W-1:0] i_pb_address,
	input [`SB_DATA_W-1:0] i_pb_wdata,
	output logic o_pb_ready,
	output logic [`SB_DATA_W-1:0] o_pb_rdata,

	// Towards the region decoder
	output logic o_req_valid,
	output bus_req_t o_req,
	output src_t o_src,
	input bus_rsp_t i_rsp
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_DONE
	} state_t;

	state_t state;
	logic grant_b;
	bus_req_t req_q;
	logic [`SB_DATA_W-1:0] rdata_q;

	// ========================================
	// Grant and transfer sequencing

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_IDLE;
			grant_b <= 1'b0;
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
		end else begin
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Port A has fixed priority
					if (i_pa_request || i_pb_request) begin
						grant_b <= !i_pa_request;
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					if (i_rsp.ready)
						state <= ST_DONE;
				end
				ST_DONE: begin
					o_pa_ready <= !grant_b;
					o_pb_ready <= grant_b;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Request and read data registers
	always_ff @(posedge i_clock) begin
		if (state == ST_IDLE) begin
			if (i_pa_request)
				req_q <= '{rw: 1'b0, address: i_pa_address, wdata: '0};
			else
				req_q <= '{rw: i_pb_rw, address: i_pb_address, wdata: i_pb_wdata};
		end
		if (state == ST_BUSY && i_rsp.ready)
			rdata_q <= i_rsp.rdata;
	end

	assign o_req_valid = (state == ST_BUSY);
	assign o_req = req_q;
	assign o_src = grant_b ? `SB_SRC_DATA : `SB_SRC_INSTR;

	// Both ports see the same read data, only the ready tells them apart
	assign o_pa_rdata = rdata_q;
	assign o_pb_rdata = rdata_q;

endmodule

//--- source/region_decoder.sv
`timescale 1ns/1ps

`include "soc_bus_defs.svh"

module region_decoder import soc_bus_pkg::*; (
	// From and to the arbiter
	input i_req_valid,
	input bus_req_t i_req,
	input src_t i_src,
	output bus_rsp_t o_rsp,

	// Block RAM
	output logic o_ram_request,
	input bus_rsp_t i_ram_rsp,

	// Peripheral bridge
	output logic o_bridge_request,
	input bus_rsp_t i_bridge_rsp,

	output bus_fault_t o_fault
);

	logic [`SB_REGION_HI-`SB_REGION_LO:0] region;
	logic ram_select;
	logic bridge_select;
	logic unmapped;

	// ========================================
	// Region select

	assign region = i_req.address[`SB_REGION_HI:`SB_REGION_LO];
	assign ram_select = (region == `SB_REGION_RAM);
	assign bridge_select = (region == `SB_REGION_BRIDGE);
	assign unmapped = !ram_select && !bridge_select;

	// Valid level goes to exactly one slave
	assign o_ram_request = i_req_valid && ram_select;
	assign o_bridge_request = i_req_valid && bridge_select;

	// ========================================
	// Response mux

	always_comb begin
		if (ram_select) begin
			o_rsp.ready = i_req_valid && i_ram_rsp.ready;
			o_rsp.rdata = i_ram_rsp.rdata;
		end else if (bridge_select) begin
			o_rsp.ready = i_req_valid && i_bridge_rsp.ready;
			o_rsp.rdata = i_bridge_rsp.rdata;
		end else begin
			// Unmapped, complete at once with zero data
			o_rsp.ready = i_req_valid;
			o_rsp.rdata = '0;
		end
	end

	// Fault report, lasts as long as the valid level
	always_comb begin
		o_fault.valid = i_req_valid && unmapped;
		o_fault.address = i_req.address;
		o_fault.src = i_src;
	end

endmodule

//--- source/block_ram.sv
`timescale 1ns/1ps

`include "soc_bus_defs.svh"

module block_ram import soc_bus_pkg::*; (
	input i_clock,
	input i_rst,
	input i_request,
	input bus_req_t i_req,
	output bus_rsp_t o_rsp
);

	logic [`SB_DATA_W-1:0] mem [0:`SB_RAM_WORDS-1];
	logic [`SB_RAM_AW-1:0] index;
	logic ready_q;
	logic [`SB_DATA_W-1:0] rdata_q;

	// Word index, upper offset bits ignored
	assign index = i_req.address[`SB_RAM_AW+1:2];

	// One pulse per request, a held request does not retrigger
	always_ff @(posedge i_clock) begin
		if (i_rst)
			ready_q <= 1'b0;
		else
			ready_q <= i_request && !ready_q;
	end

	always_ff @(posedge i_clock) begin
		if (i_request && !ready_q) begin
			if (i_req.rw)
				mem[index] <= i_req.wdata;
			rdata_q <= mem[index];
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

endmodule

//--- source/periph_bridge.sv
`timescale 1ns/1ps

`include "soc_bus_defs.svh"

module periph_bridge import soc_bus_pkg::*; (
	input i_clock,
	input i_rst,

	// Near side
	input i_request,
	input bus_req_t i_req,
	output bus_rsp_t o_rsp,

	output logic [`SB_LED_W-1:0] o_led
);

	logic far_valid;
	bus_req_t far_req;
	logic [`SB_FAR_HI-`SB_FAR_LO:0] far_slot;
	logic ready_q;
	logic [`SB_DATA_W-1:0] rdata_q;
	logic [`SB_DATA_W-1:0] timer_q;

	assign far_slot = far_req.address[`SB_FAR_HI:`SB_FAR_LO];

	// ========================================
	// Far request and handshake

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			far_valid <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= 1'b0;
			if (far_valid) begin
				ready_q <= 1'b1;
				far_valid <= 1'b0;
			end else if (i_request && !ready_q) begin
				// Near request still high during ready is not a new one
				far_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!far_valid && i_request && !ready_q)
			far_req <= i_req;
		if (far_valid) begin
			if (!far_req.rw && far_slot == `SB_FAR_TIMER)
				rdata_q <= timer_q;
			else
				rdata_q <= '0;
		end
	end

	// ========================================
	// Far slots

	// LED register, write only
	always_ff @(posedge i_clock) begin
		if (i_rst)
			o_led <= '0;
		else if (far_valid && far_req.rw && far_slot == `SB_FAR_LED)
			o_led <= far_req.wdata[`SB_LED_W-1:0];
	end

	// Free-running timer, writes are dropped
	always_ff @(posedge i_clock) begin
		if (i_rst)
			timer_q <= '0;
		else
			timer_q <= timer_q + 1'b1;
	end

	// Other slots answer with zero data
	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

endmodule

//--- source/soc_bus.sv
`timescale 1ns/1ps

`include "soc_bus_defs.svh"

module soc_bus import soc_bus_pkg::*; (
	input i_clock,
	input i_rst,

	// Port A, instruction
	input i_pa_request,
	input [`SB_DATA_W-1:0] i_pa_address,
	output logic o_pa_ready,
	output logic [`SB_DATA_W-1:0] o_pa_rdata,

	// Port B, data
	input i_pb_request,
	input i_pb_rw,
	input [`SB_DATA_W-1:0] i_pb_address,
	input [`SB_DATA_W-1:0] i_pb_wdata,
	output logic o_pb_ready,
	output logic [`SB_DATA_W-1:0] o_pb_rdata,

	output logic [`SB_LED_W-1:0] o_led,
	output bus_fault_t o_fault
);

	logic req_valid;
	bus_req_t req;
	src_t src;
	bus_rsp_t rsp;

	logic ram_request;
	bus_rsp_t ram_rsp;
	logic bridge_request;
	bus_rsp_t bridge_rsp;

	// ========================================
	// Stage 1, arbitration

	bus_arbiter arbiter (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.o_req_valid(req_valid),
		.o_req(req),
		.o_src(src),
		.i_rsp(rsp)
	);

	// ========================================
	// Stage 2, region decode

	region_decoder decoder (
		.i_req_valid(req_valid),
		.i_req(req),
		.i_src(src),
		.o_rsp(rsp),
		.o_ram_request(ram_request),
		.i_ram_rsp(ram_rsp),
		.o_bridge_request(bridge_request),
		.i_bridge_rsp(bridge_rsp),
		.o_fault(o_fault)
	);

	// ========================================
	// Stage 3, slaves

	block_ram ram (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(ram_request),
		.i_req(req),
		.o_rsp(ram_rsp)
	);

	periph_bridge bridge (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_request(bridge_request),
		.i_req(req),
		.o_rsp(bridge_rsp),
		.o_led(o_led)
	);

endmodule

//--- sim/soc_bus_assert.sv
`timescale 1ns/1ps

module soc_bus_assert import soc_bus_pkg::*; (
	input i_clock,
	input i_rst,
	input i_pa_ready,
	input i_pb_ready,
	input bus_fault_t i_fault
);

	int violations = 0;

	// ========================================
	// Handshake rules

	ready_exclusive: assert property (@(posedge i_clock) disable iff (i_rst)
		!(i_pa_ready && i_pb_ready))
		else begin
			$error("Both port ready outputs high in the same cycle");
			violations++;
		end

	pa_ready_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
		i_pa_ready |=> !i_pa_ready)
		else begin
			$error("Port A ready held longer than one cycle");
			violations++;
		end

	pb_ready_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
		i_pb_ready |=> !i_pb_ready)
		else begin
			$error("Port B ready held longer than one cycle");
			violations++;
		end

	// ========================================
	// Fault and reset rules

	fault_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
		i_fault.valid |=> !i_fault.valid)
		else begin
			$error("Fault valid held longer than one cycle");
			violations++;
		end

	// Outputs are registered, so they settle one edge into reset
	quiet_in_reset: assert property (@(posedge i_clock)
		i_rst |=> !i_pa_ready && !i_pb_ready && !i_fault.valid)
		else begin
			$error("Ready or fault high during reset");
			violations++;
		end

endmodule

//--- sim/soc_bus_tb.sv
`timescale 1ns/1ps

`include "soc_bus_defs.svh"

module soc_bus_tb import soc_bus_pkg::*; ();

	localparam int WAIT_LIMIT = 40;
	localparam int RAM_LAT = 3;
	localparam int BRIDGE_LAT = 4;
	localparam int FAULT_LAT = 2;

	logic i_clock;
	logic i_rst;
	logic i_pa_request;
	logic [`SB_DATA_W-1:0] i_pa_address;
	logic o_pa_ready;
	logic [`SB_DATA_W-1:0] o_pa_rdata;
	logic i_pb_request;
	logic i_pb_rw;
	logic [`SB_DATA_W-1:0] i_pb_address;
	logic [`SB_DATA_W-1:0] i_pb_wdata;
	logic o_pb_ready;
	logic [`SB_DATA_W-1:0] o_pb_rdata;
	logic [`SB_LED_W-1:0] o_led;
	bus_fault_t o_fault;

	logic [31:0] lcg_state = 32'hb494;
	int errors = 0;
	int cycle = 0;
	int fault_count = 0;
	logic [31:0] fault_addr;
	src_t fault_src;

	// Reference model
	logic [31:0] ram_model [0:`SB_RAM_WORDS-1];
	logic [`SB_LED_W-1:0] led_model;
	int written[$];

	soc_bus dut0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.o_led(o_led),
		.o_fault(o_fault)
	);

	bind soc_bus soc_bus_assert assert0 (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_pa_ready(o_pa_ready),
		.i_pb_ready(o_pb_ready),
		.i_fault(o_fault)
	);

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	always @(posedge i_clock)
		cycle <= cycle + 1;

	// Fault monitor, sampled mid cycle
	always @(negedge i_clock) begin
		if (o_fault.valid) begin
			fault_count++;
			fault_addr = o_fault.address;
			fault_src = o_fault.src;
		end
	end

	// ========================================
	// Helpers

	// Two LCG steps, upper halves only
	function automatic logic [31:0] next_rand();
		logic [15:0] hi;
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		hi = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {hi, lcg_state[31:16]};
	endfunction

	function automatic logic [31:0] ram_address(input int idx);
		logic [31:0] r;
		r = next_rand();
		return {`SB_REGION_RAM, r[27:11], idx[`SB_RAM_AW-1:0], r[1:0]};
	endfunction

	function automatic logic [31:0] bridge_address(input logic [3:0] slot);
		logic [31:0] r;
		r = next_rand();
		return {`SB_REGION_BRIDGE, slot, r[23:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// One master transfer, latency counted from the sampling edge
	task automatic transfer(input logic port_b, input logic rw, input logic [31:0] addr,
			input logic [31:0] wdata, input int exp_lat, output logic [31:0] rdata,
			output int done_cycle);
		int start;
		int waited;
		logic got;
		rdata = '0;
		done_cycle = 0;
		@(negedge i_clock);
		if (port_b) begin
			i_pb_request = 1'b1;
			i_pb_rw = rw;
			i_pb_address = addr;
			i_pb_wdata = wdata;
		end else begin
			i_pa_request = 1'b1;
			i_pa_address = addr;
		end
		start = cycle + 1;
		got = 1'b0;
		waited = 0;
		while (!got && waited < WAIT_LIMIT) begin
			@(negedge i_clock);
			waited++;
			got = port_b ? o_pb_ready : o_pa_ready;
		end
		if (port_b)
			i_pb_request = 1'b0;
		else
			i_pa_request = 1'b0;
		if (!got) begin
			errors++;
			$display("Timeout: port %s never got ready for address %h", port_b ? "B" : "A", addr);
		end else begin
			rdata = port_b ? o_pb_rdata : o_pa_rdata;
			done_cycle = cycle;
			check_value(port_b ? "o_pb_ready latency" : "o_pa_ready latency", exp_lat,
				cycle - start);
		end
	endtask

	// ========================================
	// Test sequence

	initial begin
		logic [31:0] addr, addr_b, data, rd, rd_b, t1, t2, r;
		int c1, c2, idx, idx_b, fault_before;
		logic pb;
		logic [3:0] region;
		i_rst = 1'b1;
		i_pa_request = 1'b0;
		i_pa_address = '0;
		i_pb_request = 1'b0;
		i_pb_rw = 1'b0;
		i_pb_address = '0;
		i_pb_wdata = '0;
		led_model = '0;
		repeat (4) @(posedge i_clock);
		@(negedge i_clock);
		i_rst = 1'b0;

		// RAM writes from the data port
		for (int i = 0; i < 48; i++) begin
			idx = next_rand() % `SB_RAM_WORDS;
			data = next_rand();
			transfer(1'b1, 1'b1, ram_address(idx), data, RAM_LAT, rd, c1);
			ram_model[idx] = data;
			written.push_back(idx);
		end

		// Unmapped regions from either port
		for (int i = 0; i < 12; i++) begin
			r = next_rand();
			data = next_rand();
			region = r[31:28];
			if (region == `SB_REGION_RAM || region == `SB_REGION_BRIDGE)
				region = region + 4'd2;
			addr = {region, data[27:0]};
			pb = r[20];
			fault_before = fault_count;
			transfer(pb, r[9], addr, data, FAULT_LAT, rd, c1);
			check_value("o_fault.valid pulses", 1, fault_count - fault_before);
			check_value("o_fault.address", addr, fault_addr);
			check_value("o_fault.src", pb ? `SB_SRC_DATA : `SB_SRC_INSTR, fault_src);
			check_value(pb ? "o_pb_rdata" : "o_pa_rdata", 0, rd);
			check_value("o_led", led_model, o_led);
		end

		// RAM read-back from both ports
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			idx = written[r % written.size()];
			pb = r[20];
			transfer(pb, 1'b0, ram_address(idx), '0, RAM_LAT, rd, c1);
			check_value(pb ? "o_pb_rdata" : "o_pa_rdata", ram_model[idx], rd);
		end

		// LED register and an empty far slot
		for (int i = 0; i < 10; i++) begin
			data = next_rand();
			transfer(1'b1, 1'b1, bridge_address(`SB_FAR_LED), data, BRIDGE_LAT, rd, c1);
			led_model = data[`SB_LED_W-1:0];
			check_value("o_led", led_model, o_led);
			transfer(1'b0, 1'b0, bridge_address(`SB_FAR_LED), '0, BRIDGE_LAT, rd, c1);
			check_value("o_pa_rdata", 0, rd);
			transfer(1'b1, 1'b0, bridge_address(4'h3), '0, BRIDGE_LAT, rd, c1);
			check_value("o_pb_rdata", 0, rd);
		end

		// Timer steps track the distance between ready pulses
		for (int i = 0; i < 4; i++) begin
			transfer(1'b1, 1'b0, bridge_address(`SB_FAR_TIMER), '0, BRIDGE_LAT, t1, c1);
			transfer(1'b0, 1'b0, bridge_address(`SB_FAR_TIMER), '0, BRIDGE_LAT, t2, c2);
			check_value("timer increasing", 1, t2 > t1);
			check_value("timer step", c2 - c1, t2 - t1);
		end

		// Both ports on the same edge, port B waits out port A plus the idle edge
		for (int i = 0; i < 8; i++) begin
			idx = written[next_rand() % written.size()];
			idx_b = written[next_rand() % written.size()];
			addr = ram_address(idx);
			addr_b = ram_address(idx_b);
			fork
				transfer(1'b0, 1'b0, addr, '0, RAM_LAT, rd, c1);
				transfer(1'b1, 1'b0, addr_b, '0, 2 * RAM_LAT + 1, rd_b, c2);
			join
			check_value("o_pa_rdata", ram_model[idx], rd);
			check_value("o_pb_rdata", ram_model[idx_b], rd_b);
			check_value("port A ready first", 1, c1 < c2);
		end

		errors += dut0.assert0.violations;
		$display("Checks finished with %0d errors", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- soc_bus.f
+incdir+source
source/soc_bus_pkg.sv
source/bus_arbiter.sv
source/region_decoder.sv
source/block_ram.sv
source/periph_bridge.sv
source/soc_bus.sv
sim/soc_bus_assert.sv
sim/soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

export_include_dirs:
  - source

sources:
  - target: any(rtl, simulation, synthesis)
    files:
      - source/soc_bus_pkg.sv
      - source/bus_arbiter.sv
      - source/region_decoder.sv
      - source/block_ram.sv
      - source/periph_bridge.sv
      - source/soc_bus.sv
  - target: simulation
    files:
      - sim/soc_bus_assert.sv
      - sim/soc_bus_tb.sv
